// ==== logic/fir_cfg.svh ====
`ifndef FIR_CFG_SVH
`define FIR_CFG_SVH

// ------------------------------
// datapath widths
// ------------------------------

`define FIR_SAMPLE_W 16
`define FIR_COEF_W 16

// wide enough for four full-scale products plus bias headroom
`define FIR_ACC_W 40
`define FIR_OUT_W 16

// ------------------------------
// filter shape
// ------------------------------

`define FIR_TAPS 4

// drop this many fraction bits before rounding to FIR_OUT_W
`define FIR_OUT_SHIFT 14

// operand, product, accumulator, output register
`define FIR_LATENCY 4

`endif

// ==== logic/dsp_types_pkg.sv ====
`default_nettype none

`include "fir_cfg.svh"

package dsp_types_pkg;

	// ------------------------------
	// derived widths
	// ------------------------------

	// full-precision multiplier output
	localparam int PROD_W = `FIR_SAMPLE_W + `FIR_COEF_W;

	// ------------------------------
	// datapath values
	// ------------------------------

	typedef logic signed [`FIR_SAMPLE_W-1:0] sample_t;
	typedef logic signed [`FIR_COEF_W-1:0] coef_t;
	typedef logic signed [PROD_W-1:0] prod_t;

	// partial sums travel down the cascade at this width
	typedef logic signed [`FIR_ACC_W-1:0] acc_t;

	// rounded and saturated output
	typedef logic signed [`FIR_OUT_W-1:0] result_t;

endpackage

`default_nettype wire

// ==== logic/fir_ctrl_pkg.sv ====
`default_nettype none

`include "fir_cfg.svh"

package fir_ctrl_pkg;

	// coefficient write address
	typedef logic [$clog2(`FIR_TAPS)-1:0] tap_idx_t;

	// per-tap alu mode, sub maps to the slice's alu_sub
	typedef enum logic {
		TAP_ADD = 1'b0,
		TAP_SUB = 1'b1
	} tap_op_t;

endpackage

`default_nettype wire

// ==== logic/stage_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

// enabled register shared by the enable delays and the output stage
module stage_reg #(
	parameter type T         = logic,
	parameter T    RESET_VAL = '0
) (
	input  wire   clk,
	input  wire   reset,
	input  wire   en,
	input  wire T d,
	output T      q
);

	// ------------------------------
	// storage
	// ------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			q <= RESET_VAL;
		end else if (en) begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

// ==== logic/coef_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fir_cfg.svh"

// per-tap coefficient and mode storage, plus the bias
module coef_bank
	import dsp_types_pkg::*;
	import fir_ctrl_pkg::*;
(
	input  wire                             clk,
	input  wire                             reset,
	input  wire                             coef_we,
	input  wire tap_idx_t                   coef_addr,
	input  wire coef_t                      coef_data,
	input  wire tap_op_t                    coef_op,
	input  wire                             bias_we,
	input  wire acc_t                       bias,
	input  wire                             sample_valid,
	output coef_t   [`FIR_TAPS-1:0]         coef_vec,
	output tap_op_t [`FIR_TAPS-1:0]         op_vec,
	output acc_t                            bias_val
);

	// ------------------------------
	// write port
	// ------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			coef_vec <= '0;
			bias_val <= '0;
			for (int k = 0; k < `FIR_TAPS; k++) begin
				op_vec[k] <= TAP_ADD;
			end
		end else begin
			if (coef_we) begin
				coef_vec[coef_addr] <= coef_data;
				op_vec[coef_addr]   <= coef_op;
			end
			if (bias_we) begin
				bias_val <= bias;
			end
		end
	end

	// cells capture h and c on the strobe, so a write there would split one sample
	a_no_write_on_strobe : assert property (@(posedge clk) disable iff (reset)
		sample_valid |-> !(coef_we || bias_we));

endmodule

`default_nettype wire

// ==== logic/mul_add_cell.sv ====
`timescale 1ns/10ps
`default_nettype none

// one dsp-slice style cell: p = (load ? c : pcin) +/- x*h
module mul_add_cell
	import dsp_types_pkg::*;
(
	input  wire       clk,
	input  wire       reset,
	input  wire       cke_in,
	input  wire       cke_m,
	input  wire       cke_p,
	input  wire       op_load,
	input  wire       sub,
	input  wire sample_t x,
	input  wire coef_t   h,
	input  wire acc_t    c,
	input  wire acc_t    pcin,
	output acc_t      pcout
);

	sample_t x_reg;
	coef_t   h_reg;
	acc_t    c_reg;
	logic    load_reg;
	logic    sub_reg;
	prod_t   m_reg;
	acc_t    m_ext;
	acc_t    p_base;
	acc_t    p_reg;

	// ------------------------------
	// operand and control stage
	// ------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			x_reg    <= '0;
			h_reg    <= '0;
			c_reg    <= '0;
			load_reg <= 1'b0;
			sub_reg  <= 1'b0;
		end else if (cke_in) begin
			x_reg    <= x;
			h_reg    <= h;
			c_reg    <= c;
			load_reg <= op_load;
			sub_reg  <= sub;
		end
	end

	// ------------------------------
	// multiplier stage
	// ------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			m_reg <= '0;
		end else if (cke_m) begin
			m_reg <= x_reg * h_reg;
		end
	end

	// sign extend up to the cascade width
	assign m_ext = acc_t'(m_reg);

	// ------------------------------
	// post-adder stage
	// ------------------------------

	// load mode takes the C port, otherwise the cascade from the tap above
	assign p_base = load_reg ? c_reg : pcin;

	always_ff @(posedge clk) begin
		if (reset) begin
			p_reg <= '0;
		end else if (cke_p) begin
			if (sub_reg) begin
				p_reg <= p_base - m_ext;
			end else begin
				p_reg <= p_base + m_ext;
			end
		end
	end

	assign pcout = p_reg;

	// no product without operands captured on an earlier strobe
	a_m_after_in : assert property (@(posedge clk) disable iff (reset)
		cke_m |-> $past(cke_in));

endmodule

`default_nettype wire

// ==== logic/fir_tap_chain.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fir_cfg.svh"

// transposed-form chain, sample broadcast, partial sums cascade toward tap 0
module fir_tap_chain
	import dsp_types_pkg::*;
	import fir_ctrl_pkg::*;
(
	input  wire                          clk,
	input  wire                          reset,
	input  wire                          cke_in,
	input  wire                          cke_m,
	input  wire                          cke_p,
	input  wire sample_t                 x,
	input  wire coef_t   [`FIR_TAPS-1:0] coef_vec,
	input  wire tap_op_t [`FIR_TAPS-1:0] op_vec,
	input  wire acc_t                    bias_val,
	output acc_t                         acc
);

	acc_t pc_out [`FIR_TAPS];

	// ------------------------------
	// cells
	// ------------------------------

	for (genvar k = 0; k < `FIR_TAPS; k++) begin : g_tap
		logic tap_load;
		acc_t tap_c;
		acc_t tap_pcin;

		// top of the chain starts from the bias
		if (k == `FIR_TAPS - 1) begin : g_last
			assign tap_load = 1'b1;
			assign tap_c    = bias_val;
			assign tap_pcin = '0;
		end else begin : g_cascade
			assign tap_load = 1'b0;
			assign tap_c    = '0;
			assign tap_pcin = pc_out[k+1];
		end

		mul_add_cell u_cell (
			.clk     (clk),
			.reset   (reset),
			.cke_in  (cke_in),
			.cke_m   (cke_m),
			.cke_p   (cke_p),
			.op_load (tap_load),
			.sub     (op_vec[k] == TAP_SUB),
			.x       (x),
			.h       (coef_vec[k]),
			.c       (tap_c),
			.pcin    (tap_pcin),
			.pcout   (pc_out[k])
		);
	end

	// tap 0 holds the full sum
	assign acc = pc_out[0];

endmodule

`default_nettype wire

// ==== logic/result_shaper.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fir_cfg.svh"

// round half up, shift, clamp, register
module result_shaper
	import dsp_types_pkg::*;
(
	input  wire       clk,
	input  wire       reset,
	input  wire       cke_out,
	input  wire acc_t acc,
	output logic      result_valid,
	output result_t   result
);

	localparam int SHIFTED_W = `FIR_ACC_W + 1 - `FIR_OUT_SHIFT;

	// result_t limits at the shifted width
	localparam logic signed [SHIFTED_W-1:0] OUT_MAX =
		{{(SHIFTED_W-`FIR_OUT_W+1){1'b0}}, {(`FIR_OUT_W-1){1'b1}}};
	localparam logic signed [SHIFTED_W-1:0] OUT_MIN =
		{{(SHIFTED_W-`FIR_OUT_W+1){1'b1}}, {(`FIR_OUT_W-1){1'b0}}};

	logic signed [`FIR_ACC_W:0]   rounded;
	logic signed [SHIFTED_W-1:0]  shifted;
	result_t                      clamped;

	// one guard bit so adding the half step never wraps
	always_comb begin
		rounded = {acc[`FIR_ACC_W-1], acc} + ((`FIR_ACC_W+1)'(1) << (`FIR_OUT_SHIFT - 1));
		shifted = rounded[`FIR_ACC_W:`FIR_OUT_SHIFT];
		if (shifted > OUT_MAX) begin
			clamped = OUT_MAX[`FIR_OUT_W-1:0];
		end else if (shifted < OUT_MIN) begin
			clamped = OUT_MIN[`FIR_OUT_W-1:0];
		end else begin
			clamped = shifted[`FIR_OUT_W-1:0];
		end
	end

	// ------------------------------
	// output register
	// ------------------------------

	stage_reg #(.T(result_t), .RESET_VAL('0)) u_result_reg (
		.clk   (clk),
		.reset (reset),
		.en    (cke_out),
		.d     (clamped),
		.q     (result)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= cke_out;
		end
	end

endmodule

`default_nettype wire

// ==== logic/fir_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fir_cfg.svh"

module fir_top
	import dsp_types_pkg::*;
	import fir_ctrl_pkg::*;
(
	input  wire           clk,
	input  wire           reset,
	input  wire           sample_valid,
	input  wire sample_t  sample,
	input  wire           coef_we,
	input  wire tap_idx_t coef_addr,
	input  wire coef_t    coef_data,
	input  wire tap_op_t  coef_op,
	input  wire           bias_we,
	input  wire acc_t     bias,
	output logic          result_valid,
	output result_t       result
);

	logic cke_in;
	logic cke_m;
	logic cke_p;
	logic cke_out;

	coef_t   [`FIR_TAPS-1:0] coef_vec;
	tap_op_t [`FIR_TAPS-1:0] op_vec;
	acc_t                    bias_val;
	acc_t                    acc;

	// ------------------------------
	// stage enables follow the strobe
	// ------------------------------

	assign cke_in = sample_valid;

	stage_reg #(.T(logic), .RESET_VAL(1'b0)) u_cke_m (
		.clk(clk), .reset(reset), .en(1'b1), .d(cke_in), .q(cke_m)
	);
	stage_reg #(.T(logic), .RESET_VAL(1'b0)) u_cke_p (
		.clk(clk), .reset(reset), .en(1'b1), .d(cke_m), .q(cke_p)
	);
	stage_reg #(.T(logic), .RESET_VAL(1'b0)) u_cke_out (
		.clk(clk), .reset(reset), .en(1'b1), .d(cke_p), .q(cke_out)
	);

	coef_bank u_coef_bank (
		.clk(clk), .reset(reset), .coef_we(coef_we), .coef_addr(coef_addr),
		.coef_data(coef_data), .coef_op(coef_op), .bias_we(bias_we), .bias(bias),
		.sample_valid(sample_valid), .coef_vec(coef_vec), .op_vec(op_vec),
		.bias_val(bias_val)
	);

	fir_tap_chain u_chain (
		.clk(clk), .reset(reset), .cke_in(cke_in), .cke_m(cke_m), .cke_p(cke_p),
		.x(sample), .coef_vec(coef_vec), .op_vec(op_vec), .bias_val(bias_val),
		.acc(acc)
	);

	result_shaper u_shaper (
		.clk(clk), .reset(reset), .cke_out(cke_out), .acc(acc),
		.result_valid(result_valid), .result(result)
	);

endmodule

`default_nettype wire

// ==== bench/fir_top_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fir_cfg.svh"

module fir_top_tb
	import dsp_types_pkg::*;
	import fir_ctrl_pkg::*;
();

	typedef enum int {STEP_COEF, STEP_BIAS, STEP_SAMPLE, STEP_GAP} step_kind_t;

	logic     clk = 1'b0;
	logic     reset = 1'b1;
	logic     sample_valid = 1'b0;
	sample_t  sample = '0;
	logic     coef_we = 1'b0;
	tap_idx_t coef_addr = '0;
	coef_t    coef_data = '0;
	tap_op_t  coef_op = TAP_ADD;
	logic     bias_we = 1'b0;
	acc_t     bias = '0;
	logic     result_valid;
	result_t  result;

	// stimulus table, one entry per step
	string      st_name[$];
	step_kind_t st_kind[$];
	int         st_addr[$];
	longint     st_value[$];
	tap_op_t    st_op[$];
	int         st_gap[$];

	// model state; history entry j is the sample strobed j strobes ago
	coef_t   coef_now[`FIR_TAPS] = '{default: '0};
	tap_op_t op_now[`FIR_TAPS] = '{default: TAP_ADD};
	acc_t    bias_now = '0;
	longint  term_hist[`FIR_TAPS][`FIR_TAPS];
	acc_t    bias_hist[`FIR_TAPS] = '{default: '0};

	result_t exp_val[$];
	string   exp_name[$];
	int      exp_cyc[$];

	int cyc = 0;
	int watchdog_cycles = 0;
	int mismatch_count = 0;
	int other_errors = 0;

	fir_top uut (
		.clk(clk), .reset(reset), .sample_valid(sample_valid), .sample(sample),
		.coef_we(coef_we), .coef_addr(coef_addr), .coef_data(coef_data), .coef_op(coef_op),
		.bias_we(bias_we), .bias(bias), .result_valid(result_valid), .result(result)
	);

	// ------------------------------
	// stimulus table
	// ------------------------------

	task automatic push_step(input string name, input step_kind_t kind, input int addr,
			input longint value, input tap_op_t op, input int gap);
		st_name.push_back(name);
		st_kind.push_back(kind);
		st_addr.push_back(addr);
		st_value.push_back(value);
		st_op.push_back(op);
		st_gap.push_back(gap);
	endtask

	task automatic build_table();
		int      base_h[`FIR_TAPS];
		sample_t rand_x[6];
		int      gap_total;
		base_h = '{1000, -2000, 3000, 4000};
		gap_total = 0;
		push_step("reset_idle", STEP_GAP, 0, 0, TAP_ADD, 5);
		for (int k = 0; k < `FIR_TAPS; k++) begin
			push_step("impulse_coef", STEP_COEF, k, base_h[k], TAP_ADD, 0);
		end
		push_step("impulse", STEP_SAMPLE, 0, 16384, TAP_ADD, 0);
		for (int j = 0; j < 4; j++) begin
			push_step("impulse_tail", STEP_SAMPLE, 0, 0, TAP_ADD, 0);
		end
		// taps 1 and 3 subtract, bias enters at the top of the chain
		push_step("sub_coef1", STEP_COEF, 1, -2000, TAP_SUB, 0);
		push_step("sub_coef3", STEP_COEF, 3, 4000, TAP_SUB, 0);
		push_step("bias_load", STEP_BIAS, 0, 123456789, TAP_ADD, 0);
		for (int j = 0; j < 6; j++) begin
			push_step("step_input", STEP_SAMPLE, 0, 1000, TAP_ADD, 0);
		end
		for (int k = 0; k < `FIR_TAPS; k++) begin
			push_step("sat_coef", STEP_COEF, k, 32767, TAP_ADD, 0);
		end
		push_step("sat_bias", STEP_BIAS, 0, 0, TAP_ADD, 0);
		for (int j = 0; j < 4; j++) begin
			push_step("sat_high", STEP_SAMPLE, 0, 32767, TAP_ADD, 0);
		end
		for (int j = 0; j < 4; j++) begin
			push_step("sat_low", STEP_SAMPLE, 0, -32768, TAP_ADD, 0);
		end
		// tap 0 alone, one lsb of input is half an output step
		for (int k = 0; k < `FIR_TAPS; k++) begin
			push_step("round_coef", STEP_COEF, k, (k == 0) ? 8192 : 0, TAP_ADD, 0);
		end
		for (int j = 0; j < 3; j++) begin
			push_step("round_flush", STEP_SAMPLE, 0, 0, TAP_ADD, 0);
		end
		push_step("round_half_pos", STEP_SAMPLE, 0, 1, TAP_ADD, 0);
		push_step("round_half_neg", STEP_SAMPLE, 0, -1, TAP_ADD, 0);
		push_step("round_odd", STEP_SAMPLE, 0, 3, TAP_ADD, 0);
		for (int k = 0; k < `FIR_TAPS; k++) begin
			push_step("burst_coef", STEP_COEF, k, base_h[k], TAP_ADD, 0);
		end
		for (int j = 0; j < 3; j++) begin
			push_step("burst_flush", STEP_SAMPLE, 0, 0, TAP_ADD, 0);
		end
		for (int j = 0; j < 6; j++) begin
			rand_x[j] = sample_t'($urandom);
			push_step("burst_back_to_back", STEP_SAMPLE, 0, longint'(rand_x[j]), TAP_ADD, 0);
		end
		for (int j = 0; j < 3; j++) begin
			push_step("burst_flush", STEP_SAMPLE, 0, 0, TAP_ADD, 0);
		end
		// same samples again, now spread out by idle cycles
		for (int j = 0; j < 6; j++) begin
			push_step("burst_gapped", STEP_SAMPLE, 0, longint'(rand_x[j]), TAP_ADD, 0);
			push_step("burst_idle", STEP_GAP, 0, 0, TAP_ADD, 1 + int'($urandom % 5));
		end
		push_step("reload_pre", STEP_SAMPLE, 0, 500, TAP_ADD, 0);
		push_step("reload_pre", STEP_SAMPLE, 0, -700, TAP_ADD, 0);
		push_step("reload_coef2", STEP_COEF, 2, -1200, TAP_SUB, 0);
		push_step("reload_post", STEP_SAMPLE, 0, 900, TAP_ADD, 0);
		for (int j = 0; j < 4; j++) begin
			push_step("reload_post", STEP_SAMPLE, 0, 300 * j - 400, TAP_ADD, 0);
		end
		foreach (st_gap[i]) begin
			gap_total += st_gap[i];
		end
		watchdog_cycles = st_kind.size() + gap_total + `FIR_LATENCY + 20;
	endtask

	// ------------------------------
	// reference model
	// ------------------------------

	function automatic result_t expected_result();
		longint sum;
		longint shifted;
		longint out_max;
		out_max = (longint'(1) <<< (`FIR_OUT_W - 1)) - 1;
		sum = longint'(bias_hist[`FIR_TAPS-1]);
		for (int k = 0; k < `FIR_TAPS; k++) begin
			sum = sum + term_hist[k][k];
		end
		shifted = (sum + (longint'(1) <<< (`FIR_OUT_SHIFT - 1))) >>> `FIR_OUT_SHIFT;
		if (shifted > out_max) begin
			shifted = out_max;
		end else if (shifted < -out_max - 1) begin
			shifted = -out_max - 1;
		end
		return result_t'(shifted);
	endfunction

	// terms use the coefficients in force when the sample was strobed
	task automatic model_strobe(input string name, input sample_t x);
		for (int j = `FIR_TAPS - 1; j > 0; j--) begin
			term_hist[j] = term_hist[j-1];
			bias_hist[j] = bias_hist[j-1];
		end
		for (int k = 0; k < `FIR_TAPS; k++) begin
			term_hist[0][k] = longint'(coef_now[k]) * longint'(x);
			if (op_now[k] == TAP_SUB) begin
				term_hist[0][k] = -term_hist[0][k];
			end
		end
		bias_hist[0] = bias_now;
		exp_val.push_back(expected_result());
		exp_name.push_back(name);
		exp_cyc.push_back(cyc + 1);
	endtask

	task automatic compare_result(input string name, input result_t expected,
			input result_t actual);
		if (expected !== actual) begin
			mismatch_count++;
			$display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic compare_latency(input string name, input int expected, input int actual);
		if (expected != actual) begin
			mismatch_count++;
			$display("MISMATCH %s latency: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	// ------------------------------
	// clock, monitor, watchdog
	// ------------------------------

	initial begin
		forever begin
			#50 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	always @(posedge clk) begin
		if (!reset && result_valid) begin
			if (exp_val.size() == 0) begin
				other_errors++;
				$display("result_valid at cycle %0d with no sample outstanding", cyc);
			end else begin
				compare_result(exp_name[0], exp_val[0], result);
				compare_latency(exp_name[0], `FIR_LATENCY, cyc - exp_cyc[0]);
				void'(exp_val.pop_front());
				void'(exp_name.pop_front());
				void'(exp_cyc.pop_front());
			end
		end
	end

	initial begin
		#1;
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout: the run did not finish within %0d clock cycles", watchdog_cycles);
		$display("Testbench failed");
		$finish;
	end

	// ------------------------------
	// driver
	// ------------------------------

	initial begin
		int drain;
		void'($urandom(32'h106853fd));
		for (int j = 0; j < `FIR_TAPS; j++) begin
			for (int k = 0; k < `FIR_TAPS; k++) begin
				term_hist[j][k] = 0;
			end
		end
		build_table();
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < st_kind.size(); i++) begin
			@(posedge clk);
			sample_valid <= (st_kind[i] == STEP_SAMPLE);
			coef_we      <= (st_kind[i] == STEP_COEF);
			bias_we      <= (st_kind[i] == STEP_BIAS);
			sample       <= sample_t'(st_value[i]);
			coef_addr    <= tap_idx_t'(st_addr[i]);
			coef_data    <= coef_t'(st_value[i]);
			coef_op      <= st_op[i];
			bias         <= acc_t'(st_value[i]);
			case (st_kind[i])
				STEP_COEF: begin
					coef_now[st_addr[i]] = coef_t'(st_value[i]);
					op_now[st_addr[i]]   = st_op[i];
				end
				STEP_BIAS: bias_now = acc_t'(st_value[i]);
				STEP_SAMPLE: model_strobe(st_name[i], sample_t'(st_value[i]));
				default: repeat (st_gap[i] - 1) @(posedge clk);
			endcase
		end
		@(posedge clk);
		sample_valid <= 1'b0;
		coef_we      <= 1'b0;
		bias_we      <= 1'b0;
		drain = 0;
		while (exp_val.size() != 0 && drain < `FIR_LATENCY + 2) begin
			@(posedge clk);
			drain++;
		end
		repeat (2) @(posedge clk);
		if (exp_val.size() != 0) begin
			other_errors += exp_val.size();
			$display("%0d expected results never appeared", exp_val.size());
		end
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, other_errors);
		if (mismatch_count == 0 && other_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+logic
logic/dsp_types_pkg.sv
logic/fir_ctrl_pkg.sv
logic/stage_reg.sv
logic/coef_bank.sv
logic/mul_add_cell.sv
logic/fir_tap_chain.sv
logic/result_shaper.sv
logic/fir_top.sv
bench/fir_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the FIR testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module fir_top_tb -f vlog.f -o fir_top_tb_sim

out=$(./obj_dir/fir_top_tb_sim) || { echo "$out"; exit 1; }
echo "$out"

if echo "$out" | grep -q "Testbench passed"; then
	exit 0
fi
exit 1
